// ==== verilog/ac97_pkg.sv ====
package ac97_pkg;

  //////////////////////////////
  // basic types
  //////////////////////////////

  // frame bit position, wraps once per frame
  typedef logic [7:0]  bit_count_t;
  typedef logic [19:0] slot_t;
  // 8-bit pcm, top byte of a slot
  typedef logic [7:0]  sample_t;
  typedef logic [7:0]  cmd_addr_t;
  typedef logic [15:0] cmd_data_t;
  typedef logic [4:0]  volume_t;

  //////////////////////////////
  // frame layout
  //////////////////////////////

  localparam int frame_bits = 256;
  localparam int slot_bits  = 20;
  localparam int tag_bits   = 16;

  // sync rises on the last bit of a frame and drops after the tag slot
  localparam bit_count_t sync_start_bit = 8'd255;
  localparam bit_count_t sync_end_bit   = 8'd15;
  // mid frame, well clear of the slots in use
  localparam bit_count_t ready_bit      = 8'd128;

  // first bit of each data slot
  localparam bit_count_t slot1_first = 8'd16;
  localparam bit_count_t slot2_first = 8'd36;
  localparam bit_count_t slot3_first = 8'd56;
  localparam bit_count_t slot4_first = 8'd76;

  //////////////////////////////
  // volume, tone
  //////////////////////////////

  localparam volume_t volume_reset_value = 5'd8;
  localparam volume_t volume_max         = 5'd31;

  localparam int tone_steps = 64;

  //////////////////////////////
  // codec registers
  //////////////////////////////

  // bit 7 of the address marks a read, so 80 reads the reset/id register
  localparam cmd_addr_t reg_reset_id         = 8'h80;
  localparam cmd_addr_t reg_headphone_volume = 8'h04;
  localparam cmd_addr_t reg_pcm_volume       = 8'h18;
  localparam cmd_addr_t reg_record_select    = 8'h1A;
  localparam cmd_addr_t reg_record_gain      = 8'h1C;
  localparam cmd_addr_t reg_mic_gain         = 8'h0E;
  localparam cmd_addr_t reg_beep_volume      = 8'h0A;
  localparam cmd_addr_t reg_general_purpose  = 8'h20;

  localparam cmd_data_t pcm_volume_data      = 16'h0808;
  // mic on both channels
  localparam cmd_data_t record_select_data   = 16'h0000;
  // record gain at max
  localparam cmd_data_t record_gain_data     = 16'h0F0F;
  // +20 dB mic boost
  localparam cmd_data_t mic_gain_data        = 16'h8048;
  localparam cmd_data_t beep_volume_data     = 16'h0000;
  // pcm out bypasses 3d mix
  localparam cmd_data_t general_purpose_data = 16'h8000;

  // one step per frame, sixteen steps then wrap
  typedef enum logic [3:0] {
    step_read_id          = 4'd0,
    step_idle_read_1      = 4'd1,
    step_idle_read_2      = 4'd2,
    step_headphone_volume = 4'd3,
    step_idle_read_4      = 4'd4,
    step_pcm_volume       = 4'd5,
    step_record_select    = 4'd6,
    step_record_gain      = 4'd7,
    step_idle_read_8      = 4'd8,
    step_mic_gain         = 4'd9,
    step_beep_volume      = 4'd10,
    step_pcm_bypass       = 4'd11,
    step_idle_read_12     = 4'd12,
    step_idle_read_13     = 4'd13,
    step_idle_read_14     = 4'd14,
    step_idle_read_15     = 4'd15
  } command_step_e;

endpackage

// ==== verilog/ac97_frame_engine.sv ====
`timescale 1ns/1ns

module ac97_frame_engine (
  input  logic                clock,
  input  logic                reset,
  input  ac97_pkg::cmd_addr_t command_address,
  input  ac97_pkg::cmd_data_t command_data,
  input  logic                command_valid,
  input  ac97_pkg::sample_t   out_sample,
  input  logic                ac97_sdata_in,
  output logic                frame_ready,
  output logic                ac97_synch,
  output logic                ac97_sdata_out,
  output ac97_pkg::sample_t   left_in_sample
);

  localparam ac97_pkg::bit_count_t last_bit =
    ac97_pkg::bit_count_t'(ac97_pkg::frame_bits - 1);
  localparam ac97_pkg::bit_count_t tag_end = ac97_pkg::bit_count_t'(ac97_pkg::tag_bits);
  // one past the last bit of slot 4
  localparam ac97_pkg::bit_count_t slot4_end =
    ac97_pkg::bit_count_t'(ac97_pkg::slot4_first + ac97_pkg::slot_bits);
  // input bits land one position late since they are sampled on the rising edge
  localparam ac97_pkg::bit_count_t left_in_first = ac97_pkg::slot3_first + 8'd1;
  localparam ac97_pkg::bit_count_t left_in_last =
    ac97_pkg::bit_count_t'(ac97_pkg::slot3_first + ac97_pkg::slot_bits);
  localparam ac97_pkg::bit_count_t left_in_done = left_in_last + 8'd1;

  ac97_pkg::bit_count_t bit_count;
  logic                 frame_live;
  logic                 latched_valid;
  ac97_pkg::slot_t      latched_addr;
  ac97_pkg::slot_t      latched_data;
  ac97_pkg::slot_t      latched_pcm;
  ac97_pkg::slot_t      left_shift;
  logic                 next_bit;

  // msb first, bit (pos - first) of a slot
  function automatic logic slot_bit(ac97_pkg::slot_t value, ac97_pkg::bit_count_t first,
                                    ac97_pkg::bit_count_t pos);
    logic [4:0] offset;
    offset = 5'(pos - first);
    return value[5'(ac97_pkg::slot_bits - 1) - offset];
  endfunction

  //////////////////////////////
  // outgoing bit select
  //////////////////////////////

  always_comb begin
    next_bit = 1'b0;
    if (bit_count < tag_end) begin
      // tag slot: frame valid, cmd addr/data valid, left/right valid
      case (bit_count[3:0])
        4'd0:       next_bit = 1'b1;
        4'd1, 4'd2: next_bit = latched_valid;
        4'd3, 4'd4: next_bit = 1'b1;
        default:    next_bit = 1'b0;
      endcase
    end else if (bit_count < ac97_pkg::slot2_first) begin
      next_bit = latched_valid & slot_bit(latched_addr, ac97_pkg::slot1_first, bit_count);
    end else if (bit_count < ac97_pkg::slot3_first) begin
      next_bit = latched_valid & slot_bit(latched_data, ac97_pkg::slot2_first, bit_count);
    end else if (bit_count < ac97_pkg::slot4_first) begin
      next_bit = slot_bit(latched_pcm, ac97_pkg::slot3_first, bit_count);
    end else if (bit_count < slot4_end) begin
      // right channel repeats the mono sample
      next_bit = slot_bit(latched_pcm, ac97_pkg::slot4_first, bit_count);
    end
  end

  //////////////////////////////
  // bit counter, sync, ready
  //////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      bit_count      <= '0;
      ac97_synch     <= 1'b0;
      frame_ready    <= 1'b0;
      ac97_sdata_out <= 1'b0;
      frame_live     <= 1'b0;
      latched_valid  <= 1'b0;
    end else begin
      bit_count <= (bit_count == last_bit) ? '0 : bit_count + 8'd1;
      // sync leads the tag slot by one bit
      if (bit_count == ac97_pkg::sync_start_bit) begin
        ac97_synch <= 1'b1;
      end else if (bit_count == ac97_pkg::sync_end_bit) begin
        ac97_synch <= 1'b0;
      end
      frame_ready    <= (bit_count == ac97_pkg::ready_bit);
      // line stays quiet until the first payload is latched
      ac97_sdata_out <= next_bit & frame_live;
      // empty command slots in the first frame after reset
      if (bit_count == last_bit) begin
        latched_valid <= command_valid;
        frame_live    <= 1'b1;
      end
    end
  end

  // frame payload, taken once at the end of each frame
  always_ff @(posedge clock) begin
    if (bit_count == last_bit) begin
      latched_addr <= {command_address, 12'h000};
      latched_data <= {command_data, 4'h0};
      latched_pcm  <= {out_sample, 12'h000};
    end
  end

  //////////////////////////////
  // left slot receive
  //////////////////////////////

  always_ff @(posedge clock) begin
    if (bit_count >= left_in_first && bit_count <= left_in_last) begin
      left_shift <= {left_shift[18:0], ac97_sdata_in};
    end
    // only the top byte is kept
    if (bit_count == left_in_done) begin
      left_in_sample <= left_shift[19:12];
    end
  end

endmodule

// ==== verilog/ac97_command_sequencer.sv ====
`timescale 1ns/1ns

module ac97_command_sequencer #(
  parameter int reset_delay = 1023
) (
  input  logic                clock,
  input  logic                reset,
  input  logic                frame_ready,
  input  logic                volume_up,
  input  logic                volume_down,
  output logic                audio_reset_b,
  output ac97_pkg::cmd_addr_t command_address,
  output ac97_pkg::cmd_data_t command_data,
  output logic                command_valid
);

  localparam int delay_bits = $clog2(reset_delay + 1);

  logic [delay_bits-1:0]   delay_count;
  ac97_pkg::command_step_e step;
  ac97_pkg::volume_t       volume;
  ac97_pkg::volume_t       volume_after_up;
  ac97_pkg::volume_t       attenuation;
  logic                    up_prev;
  logic                    down_prev;
  logic                    up_edge;
  logic                    down_edge;

  //////////////////////////////
  // codec reset delay
  //////////////////////////////

  // hold the codec in reset, then release it and start commands together
  always_ff @(posedge clock) begin
    if (reset) begin
      delay_count   <= '0;
      audio_reset_b <= 1'b0;
      command_valid <= 1'b0;
    end else if (!audio_reset_b) begin
      if (delay_count == delay_bits'(reset_delay - 1)) begin
        audio_reset_b <= 1'b1;
        command_valid <= 1'b1;
      end else begin
        delay_count <= delay_count + 1'b1;
      end
    end
  end

  //////////////////////////////
  // volume
  //////////////////////////////

  assign up_edge   = volume_up & ~up_prev;
  assign down_edge = volume_down & ~down_prev;

  // up first, then down on the result
  assign volume_after_up = (up_edge && volume != ac97_pkg::volume_max) ?
                           volume + 5'd1 : volume;

  always_ff @(posedge clock) begin
    up_prev   <= volume_up;
    down_prev <= volume_down;
    if (reset) begin
      volume <= ac97_pkg::volume_reset_value;
    end else if (down_edge && volume_after_up != '0) begin
      volume <= volume_after_up - 5'd1;
    end else begin
      volume <= volume_after_up;
    end
  end

  // codec takes attenuation, not gain
  assign attenuation = ac97_pkg::volume_max - volume;

  //////////////////////////////
  // command steps
  //////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      step <= ac97_pkg::step_read_id;
    end else if (frame_ready && command_valid) begin
      step <= ac97_pkg::command_step_e'(step + 4'd1);
    end
  end

  always_ff @(posedge clock) begin
    case (step)
      ac97_pkg::step_headphone_volume: begin
        command_address <= ac97_pkg::reg_headphone_volume;
        command_data    <= {3'b000, attenuation, 3'b000, attenuation};
      end
      ac97_pkg::step_pcm_volume: begin
        command_address <= ac97_pkg::reg_pcm_volume;
        command_data    <= ac97_pkg::pcm_volume_data;
      end
      ac97_pkg::step_record_select: begin
        command_address <= ac97_pkg::reg_record_select;
        command_data    <= ac97_pkg::record_select_data;
      end
      ac97_pkg::step_record_gain: begin
        command_address <= ac97_pkg::reg_record_gain;
        command_data    <= ac97_pkg::record_gain_data;
      end
      ac97_pkg::step_mic_gain: begin
        command_address <= ac97_pkg::reg_mic_gain;
        command_data    <= ac97_pkg::mic_gain_data;
      end
      ac97_pkg::step_beep_volume: begin
        command_address <= ac97_pkg::reg_beep_volume;
        command_data    <= ac97_pkg::beep_volume_data;
      end
      ac97_pkg::step_pcm_bypass: begin
        command_address <= ac97_pkg::reg_general_purpose;
        command_data    <= ac97_pkg::general_purpose_data;
      end
      // read id and the idle steps all read the id register
      default: begin
        command_address <= ac97_pkg::reg_reset_id;
        command_data    <= '0;
      end
    endcase
  end

endmodule

// ==== verilog/audio_sample_path.sv ====
`timescale 1ns/1ns

module audio_sample_path (
  input  logic              clock,
  input  logic              reset,
  input  logic              frame_ready,
  input  logic              tone_select,
  input  ac97_pkg::sample_t left_in_sample,
  output ac97_pkg::sample_t out_sample
);

  localparam int index_bits = $clog2(ac97_pkg::tone_steps);

  logic [index_bits-1:0] tone_index;
  ac97_pkg::sample_t     tone_sample;

  //////////////////////////////
  // tone index, sample select
  //////////////////////////////

  // one table step per frame
  always_ff @(posedge clock) begin
    if (reset) begin
      tone_index <= '0;
    end else if (frame_ready) begin
      tone_index <= tone_index + 1'b1;
    end
  end

  // tone at the current index, or last received left sample
  always_ff @(posedge clock) begin
    if (frame_ready) begin
      out_sample <= tone_select ? tone_sample : left_in_sample;
    end
  end

  //////////////////////////////
  // sine table
  //////////////////////////////

  // one period in 64 steps, two's complement
  always_comb begin
    case (tone_index)
      6'h00: tone_sample = 8'h00;
      6'h01: tone_sample = 8'h0C;
      6'h02: tone_sample = 8'h18;
      6'h03: tone_sample = 8'h25;
      6'h04: tone_sample = 8'h30;
      6'h05: tone_sample = 8'h3C;
      6'h06: tone_sample = 8'h47;
      6'h07: tone_sample = 8'h51;
      6'h08: tone_sample = 8'h5A;
      6'h09: tone_sample = 8'h62;
      6'h0A: tone_sample = 8'h6A;
      6'h0B: tone_sample = 8'h70;
      6'h0C: tone_sample = 8'h76;
      6'h0D: tone_sample = 8'h7A;
      6'h0E: tone_sample = 8'h7D;
      6'h0F: tone_sample = 8'h7F;
      // positive peak
      6'h10: tone_sample = 8'h7F;
      6'h11: tone_sample = 8'h7F;
      6'h12: tone_sample = 8'h7D;
      6'h13: tone_sample = 8'h7A;
      6'h14: tone_sample = 8'h76;
      6'h15: tone_sample = 8'h70;
      6'h16: tone_sample = 8'h6A;
      6'h17: tone_sample = 8'h62;
      6'h18: tone_sample = 8'h5A;
      6'h19: tone_sample = 8'h51;
      6'h1A: tone_sample = 8'h47;
      6'h1B: tone_sample = 8'h3C;
      6'h1C: tone_sample = 8'h30;
      6'h1D: tone_sample = 8'h25;
      6'h1E: tone_sample = 8'h18;
      6'h1F: tone_sample = 8'h0C;
      // zero crossing, negative half
      6'h20: tone_sample = 8'h00;
      6'h21: tone_sample = 8'hF3;
      6'h22: tone_sample = 8'hE7;
      6'h23: tone_sample = 8'hDA;
      6'h24: tone_sample = 8'hCF;
      6'h25: tone_sample = 8'hC3;
      6'h26: tone_sample = 8'hB8;
      6'h27: tone_sample = 8'hAE;
      6'h28: tone_sample = 8'hA5;
      6'h29: tone_sample = 8'h9D;
      6'h2A: tone_sample = 8'h95;
      6'h2B: tone_sample = 8'h8F;
      6'h2C: tone_sample = 8'h89;
      6'h2D: tone_sample = 8'h85;
      6'h2E: tone_sample = 8'h82;
      6'h2F: tone_sample = 8'h80;
      // negative peak
      6'h30: tone_sample = 8'h80;
      6'h31: tone_sample = 8'h80;
      6'h32: tone_sample = 8'h82;
      6'h33: tone_sample = 8'h85;
      6'h34: tone_sample = 8'h89;
      6'h35: tone_sample = 8'h8F;
      6'h36: tone_sample = 8'h95;
      6'h37: tone_sample = 8'h9D;
      6'h38: tone_sample = 8'hA5;
      6'h39: tone_sample = 8'hAE;
      6'h3A: tone_sample = 8'hB8;
      6'h3B: tone_sample = 8'hC3;
      6'h3C: tone_sample = 8'hCF;
      6'h3D: tone_sample = 8'hDA;
      6'h3E: tone_sample = 8'hE7;
      6'h3F: tone_sample = 8'hF3;
    endcase
  end

endmodule

// ==== verilog/ac97_audio_top.sv ====
`timescale 1ns/1ns

module ac97_audio_top #(
  parameter int reset_delay = 1023
) (
  input  logic clock,
  input  logic reset,
  input  logic volume_up,
  input  logic volume_down,
  input  logic tone_select,
  input  logic ac97_sdata_in,
  output logic audio_reset_b,
  output logic ac97_synch,
  output logic ac97_sdata_out
);

  //////////////////////////////
  // internal nets
  //////////////////////////////

  // once per frame, mid frame
  logic                frame_ready;
  ac97_pkg::sample_t   left_in_sample;
  ac97_pkg::sample_t   out_sample;
  // register command toward the codec
  ac97_pkg::cmd_addr_t command_address;
  ac97_pkg::cmd_data_t command_data;
  logic                command_valid;

  // serial frame build and take apart
  ac97_frame_engine u_frame_engine (
    .clock           (clock),
    .reset           (reset),
    .command_address (command_address),
    .command_data    (command_data),
    .command_valid   (command_valid),
    .out_sample      (out_sample),
    .ac97_sdata_in   (ac97_sdata_in),
    .frame_ready     (frame_ready),
    .ac97_synch      (ac97_synch),
    .ac97_sdata_out  (ac97_sdata_out),
    .left_in_sample  (left_in_sample)
  );

  // codec reset, volume, register setup loop
  ac97_command_sequencer #(
    .reset_delay (reset_delay)
  ) u_command_sequencer (
    .clock           (clock),
    .reset           (reset),
    .frame_ready     (frame_ready),
    .volume_up       (volume_up),
    .volume_down     (volume_down),
    .audio_reset_b   (audio_reset_b),
    .command_address (command_address),
    .command_data    (command_data),
    .command_valid   (command_valid)
  );

  // tone or loopback, one sample per frame
  audio_sample_path u_sample_path (
    .clock          (clock),
    .reset          (reset),
    .frame_ready    (frame_ready),
    .tone_select    (tone_select),
    .left_in_sample (left_in_sample),
    .out_sample     (out_sample)
  );

endmodule

// ==== verif/tb_ac97_model.svh ====
`ifndef TB_AC97_MODEL_SVH
`define TB_AC97_MODEL_SVH

//////////////////////////////
// tone model
//////////////////////////////

// one sine period, top byte of each 20-bit sample
localparam logic [7:0] tone_table [64] = '{
  8'h00, 8'h0C, 8'h18, 8'h25, 8'h30, 8'h3C, 8'h47, 8'h51,
  8'h5A, 8'h62, 8'h6A, 8'h70, 8'h76, 8'h7A, 8'h7D, 8'h7F,
  8'h7F, 8'h7F, 8'h7D, 8'h7A, 8'h76, 8'h70, 8'h6A, 8'h62,
  8'h5A, 8'h51, 8'h47, 8'h3C, 8'h30, 8'h25, 8'h18, 8'h0C,
  8'h00, 8'hF3, 8'hE7, 8'hDA, 8'hCF, 8'hC3, 8'hB8, 8'hAE,
  8'hA5, 8'h9D, 8'h95, 8'h8F, 8'h89, 8'h85, 8'h82, 8'h80,
  8'h80, 8'h80, 8'h82, 8'h85, 8'h89, 8'h8F, 8'h95, 8'h9D,
  8'hA5, 8'hAE, 8'hB8, 8'hC3, 8'hCF, 8'hDA, 8'hE7, 8'hF3
};

//////////////////////////////
// volume model
//////////////////////////////

// up applies first, then down on the result, both saturate
function automatic ac97_pkg::volume_t next_volume(ac97_pkg::volume_t volume,
                                                  logic up_edge, logic down_edge);
  ac97_pkg::volume_t result;
  result = volume;
  if (up_edge && result != 5'd31)
    result = result + 5'd1;
  if (down_edge && result != 5'd0)
    result = result - 5'd1;
  return result;
endfunction

//////////////////////////////
// command table
//////////////////////////////

// {address, data} that a step sends
function automatic logic [23:0] expected_command(logic [3:0] step, ac97_pkg::volume_t volume);
  logic [4:0] atten;
  atten = 5'd31 - volume;
  case (step)
    ac97_pkg::step_headphone_volume: return {8'h04, 3'b000, atten, 3'b000, atten};
    ac97_pkg::step_pcm_volume:       return {8'h18, 16'h0808};
    ac97_pkg::step_record_select:    return {8'h1A, 16'h0000};
    ac97_pkg::step_record_gain:      return {8'h1C, 16'h0F0F};
    ac97_pkg::step_mic_gain:         return {8'h0E, 16'h8048};
    ac97_pkg::step_beep_volume:      return {8'h0A, 16'h0000};
    ac97_pkg::step_pcm_bypass:       return {8'h20, 16'h8000};
    // id read, also every idle step
    default:                         return {8'h80, 16'h0000};
  endcase
endfunction

`endif

// ==== verif/tb_ac97_audio.sv ====
`timescale 1ns/1ns

module tb_ac97_audio;

  `include "tb_ac97_model.svh"

  localparam int reset_delay  = 40;
  localparam int reset_cycles = 4;
  localparam int run_frames   = 60;
  // 60 frames of 256 bits, the frame before first sync, and margin
  localparam int max_cycles   = 20000;
  // buttons idle near the frame end, so the latched command has a settled volume
  localparam int button_last_pos = 239;
  // input slot 3 lands one position late, top byte only
  localparam int left_first = int'(ac97_pkg::slot3_first) + 1;
  localparam int sync_last  = int'(ac97_pkg::sync_end_bit);

  logic clock;
  logic reset;
  logic volume_up;
  logic volume_down;
  logic tone_select;
  logic ac97_sdata_in;
  logic audio_reset_b;
  logic ac97_synch;
  logic ac97_sdata_out;

  integer            seed;
  logic [31:0]       r;
  int                errors;
  int                cycles;
  int                since_reset;
  int                frames_checked;
  // position from sync rise, -1 until the first sync
  int                pos;
  int                frame_count;
  logic [0:255]      line_bits;
  logic [7:0]        left_cur;
  logic [7:0]        left_prev;
  logic              mode_cur;
  logic              mode_prev;
  logic              frame_cmd_on;
  ac97_pkg::volume_t volume_model;
  ac97_pkg::volume_t frame_volume;

  ac97_audio_top #(
    .reset_delay (reset_delay)
  ) u_ac97_audio_top (
    .clock          (clock),
    .reset          (reset),
    .volume_up      (volume_up),
    .volume_down    (volume_down),
    .tone_select    (tone_select),
    .ac97_sdata_in  (ac97_sdata_in),
    .audio_reset_b  (audio_reset_b),
    .ac97_synch     (ac97_synch),
    .ac97_sdata_out (ac97_sdata_out)
  );

  always #2 clock = ~clock;

  //////////////////////////////
  // frame checks
  //////////////////////////////

  task automatic check_frame(int frame_index);
    logic [23:0] command;
    logic [15:0] tag_expected;
    logic [19:0] got;
    logic [19:0] expected;
    logic [7:0]  sample;
    // frame valid, cmd addr/data valid, left/right valid
    tag_expected = {1'b1, frame_cmd_on, frame_cmd_on, 2'b11, 11'd0};
    if (line_bits[0:15] !== tag_expected) begin
      $display("ERROR tag got %h expected %h", line_bits[0:15], tag_expected);
      errors++;
    end
    // one frame_ready falls before the first sync, so frame k sends step k+1
    command = expected_command(4'((frame_index + 1) % 16), frame_volume);
    got = line_bits[ac97_pkg::slot1_first +: ac97_pkg::slot_bits];
    expected = frame_cmd_on ? {command[23:16], 12'h000} : 20'h0;
    if (got !== expected) begin
      $display("ERROR slot1 got %h expected %h", got, expected);
      errors++;
    end
    got = line_bits[ac97_pkg::slot2_first +: ac97_pkg::slot_bits];
    expected = frame_cmd_on ? {command[15:0], 4'h0} : 20'h0;
    if (got !== expected) begin
      $display("ERROR slot2 got %h expected %h", got, expected);
      errors++;
    end
    // sample chosen in the previous frame, tone index k at its frame_ready
    if (frame_index > 0) begin
      sample = mode_prev ? tone_table[6'(frame_index)] : left_prev;
      expected = {sample, 12'h000};
      got = line_bits[ac97_pkg::slot3_first +: ac97_pkg::slot_bits];
      if (got !== expected) begin
        $display("ERROR slot3 got %h expected %h", got, expected);
        errors++;
      end
      got = line_bits[ac97_pkg::slot4_first +: ac97_pkg::slot_bits];
      if (got !== expected) begin
        $display("ERROR slot4 got %h expected %h", got, expected);
        errors++;
      end
    end
    frames_checked++;
  endtask

  // close the last frame, then snapshot what the new one carries
  task automatic start_frame;
    if (frame_count > 0)
      check_frame(frame_count - 1);
    mode_prev    = mode_cur;
    left_prev    = left_cur;
    // commands enabled one clock before the payload latch at the frame end
    frame_cmd_on = (since_reset > reset_delay);
    frame_volume = volume_model;
    frame_count++;
  endtask

  //////////////////////////////
  // stimulus
  //////////////////////////////

  task automatic drive_inputs(logic [31:0] rnd);
    logic up;
    logic down;
    up   = 1'b0;
    down = 1'b0;
    if (pos >= 0 && pos <= button_last_pos) begin
      up   = rnd[0] & rnd[1];
      down = rnd[2] & rnd[3];
    end
    // edge against the level driven last cycle
    volume_model  = next_volume(volume_model, up & ~volume_up, down & ~volume_down);
    volume_up     = up;
    volume_down   = down;
    ac97_sdata_in = rnd[4];
    if (pos >= left_first && pos < left_first + 8)
      left_cur = {left_cur[6:0], rnd[4]};
    // mode held for a whole frame
    if (pos == 0) begin
      if (rnd[6:5] == 2'b00)
        tone_select = ~tone_select;
      mode_cur = tone_select;
    end
  endtask

  initial begin
    seed = 32'h5aef_3eee;
    clock = 1'b0;
    reset = 1'b1;
    volume_up = 1'b0;
    volume_down = 1'b0;
    tone_select = 1'b0;
    ac97_sdata_in = 1'b0;
    errors = 0;
    cycles = 0;
    since_reset = 0;
    frames_checked = 0;
    pos = -1;
    frame_count = 0;
    volume_model = ac97_pkg::volume_reset_value;
    left_cur = 8'h00;
    mode_cur = 1'b0;

    // everything low while reset is held
    repeat (reset_cycles) begin
      @(negedge clock);
      cycles++;
      if ({audio_reset_b, ac97_synch, ac97_sdata_out} !== 3'b000) begin
        $display("ERROR outputs in reset got %h expected %h",
                 {audio_reset_b, ac97_synch, ac97_sdata_out}, 3'b000);
        errors++;
      end
    end
    reset = 1'b0;

    while (frames_checked < run_frames && cycles < max_cycles) begin
      @(negedge clock);
      cycles++;
      since_reset++;
      r = $random(seed);
      if (audio_reset_b !== (since_reset >= reset_delay)) begin
        $display("ERROR audio_reset_b got %h expected %h", audio_reset_b,
                 since_reset >= reset_delay);
        errors++;
      end
      if (pos < 0) begin
        if (since_reset < reset_delay && ac97_synch !== 1'b0) begin
          $display("ERROR ac97_synch got %h expected %h", ac97_synch, 1'b0);
          errors++;
        end
        // line quiet while the codec is still held in reset
        if (since_reset < reset_delay && ac97_sdata_out !== 1'b0) begin
          $display("ERROR ac97_sdata_out got %h expected %h", ac97_sdata_out, 1'b0);
          errors++;
        end
        if (ac97_synch === 1'b1) begin
          pos = 0;
          start_frame();
        end
      end else begin
        pos = (pos + 1) % ac97_pkg::frame_bits;
        // sync high for the first 16 positions of every frame
        if (ac97_synch !== (pos <= sync_last)) begin
          $display("ERROR ac97_synch got %h expected %h", ac97_synch, pos <= sync_last);
          errors++;
        end
        // the line trails the position by one bit
        if (pos == 0) begin
          line_bits[255] = ac97_sdata_out;
          start_frame();
        end else begin
          line_bits[8'(pos - 1)] = ac97_sdata_out;
        end
      end
      drive_inputs(r);
    end

    if (frames_checked < run_frames) begin
      $display("timeout after %0d cycles with only %0d frames checked", cycles,
               frames_checked);
      errors++;
    end
    $display("errors: %0d, frames checked: %0d", errors, frames_checked);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+verif
verilog/ac97_pkg.sv
verilog/ac97_frame_engine.sv
verilog/ac97_command_sequencer.sv
verilog/audio_sample_path.sv
verilog/ac97_audio_top.sv
verif/tb_ac97_audio.sv

// ==== run.sh ====
#!/bin/bash
# build the testbench with Verilator, run it, and pass only on the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary -j 0 --top-module tb_ac97_audio -f flist.f -o sim_ac97 \
  && ./obj_dir/sim_ac97 | tee /dev/stderr | grep -q "TESTS PASSED" \
  && echo "simulation run ok" \
  || { echo "simulation run not ok"; exit 1; }
